// ==== Makefile ====
TOP := tb_uart_baud
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ns -f tb.f --top-module $(TOP)
	verilator --lint-only -Wall --timescale 1ns/1ns +incdir+include \
		source/uart_baud_pkg.sv source/key_filter.sv source/baud_select.sv \
		source/uart_tx.sv source/uart_baud_top.sv --top-module uart_baud_top

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f tb.f \
		--top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "Simulation failed."; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "Simulation stopped without a result."; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== include/uart_baud_config.svh ====
`ifndef UART_BAUD_CONFIG_SVH
`define UART_BAUD_CONFIG_SVH

//////////////////////////////////////////////////
// Clock and key timing
//////////////////////////////////////////////////

`define UART_CLK_FREQ_HZ      25000000
`define UART_DEBOUNCE_CYCLES  500000     // 20 ms at 25 MHz.

//////////////////////////////////////////////////
// Bit periods in sys_clk cycles
//////////////////////////////////////////////////

// Rounded down from UART_CLK_FREQ_HZ / rate.
`define UART_DIV_9600         2604
`define UART_DIV_19200        1302
`define UART_DIV_38400        651
`define UART_DIV_57600        434
`define UART_DIV_115200       217       // Rate error stays under 0.2 %.

`endif

// ==== source/baud_select.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_baud_config.svh"

module baud_select (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        key_pulse,
    output logic [11:0] bit_divisor,
    output logic [23:0] baud_bcd
);

    uart_baud_pkg::baud_rate_t rate_idx;
    uart_baud_pkg::baud_rate_t next_rate;
    logic [11:0]               next_divisor;
    logic [23:0]               next_bcd;

    //////////////////////////////////////////////////
    // Rate stepping
    //////////////////////////////////////////////////

    always_comb begin
        next_rate = rate_idx;
        if (key_pulse) begin
            if (rate_idx == uart_baud_pkg::BAUD_115200) begin
                next_rate = uart_baud_pkg::BAUD_9600;
            end else begin
                next_rate = uart_baud_pkg::baud_rate_t'(rate_idx + 3'd1);
            end
        end
    end

    //////////////////////////////////////////////////
    // Divisor and display lookup
    //////////////////////////////////////////////////

    // BCD digits are right aligned on six places.
    always_comb begin
        case (next_rate)
            uart_baud_pkg::BAUD_19200: begin
                next_divisor = 12'(`UART_DIV_19200);
                next_bcd     = 24'h019200;
            end
            uart_baud_pkg::BAUD_38400: begin
                next_divisor = 12'(`UART_DIV_38400);
                next_bcd     = 24'h038400;
            end
            uart_baud_pkg::BAUD_57600: begin
                next_divisor = 12'(`UART_DIV_57600);
                next_bcd     = 24'h057600;
            end
            uart_baud_pkg::BAUD_115200: begin
                next_divisor = 12'(`UART_DIV_115200);
                next_bcd     = 24'h115200;
            end
            default: begin                      // BAUD_9600.
                next_divisor = 12'(`UART_DIV_9600);
                next_bcd     = 24'h009600;
            end
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rate_idx    <= uart_baud_pkg::BAUD_9600;
            bit_divisor <= 12'(`UART_DIV_9600);
            baud_bcd    <= 24'h009600;
        end else begin
            rate_idx    <= next_rate;
            bit_divisor <= next_divisor;        // Lands with the index.
            baud_bcd    <= next_bcd;
        end
    end

endmodule

`default_nettype wire

// ==== source/key_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_baud_config.svh"

module key_filter #(
    parameter int DEBOUNCE_CYCLES = `UART_DEBOUNCE_CYCLES
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic key_in,
    output logic key_pulse
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic [1:0]                 key_sync;     // Bit 1 is the usable key level.
    logic [CNT_W-1:0]           stable_cnt;
    uart_baud_pkg::key_state_t  key_state;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            key_sync <= 2'b11;                  // Key idles high.
        end else begin
            key_sync <= {key_sync[0], key_in};
        end
    end

    // Counts cycles of one key level, restarted on any change.
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            key_state  <= uart_baud_pkg::KEY_RELEASED;
            stable_cnt <= '0;
            key_pulse  <= 1'b0;
        end else begin
            key_pulse <= 1'b0;
            case (key_state)
                uart_baud_pkg::KEY_RELEASED: begin
                    if (!key_sync[1]) begin
                        key_state  <= uart_baud_pkg::KEY_SETTLING;
                        stable_cnt <= CNT_W'(1);  // First low cycle seen.
                    end
                end
                uart_baud_pkg::KEY_SETTLING: begin
                    if (key_sync[1]) begin
                        key_state  <= uart_baud_pkg::KEY_RELEASED;
                        stable_cnt <= '0;
                    end else if (stable_cnt == CNT_LAST) begin
                        key_state  <= uart_baud_pkg::KEY_PRESSED;
                        stable_cnt <= '0;
                        key_pulse  <= 1'b1;       // One pulse per press.
                    end else begin
                        stable_cnt <= stable_cnt + 1'b1;
                    end
                end
                uart_baud_pkg::KEY_PRESSED: begin
                    if (!key_sync[1]) begin
                        stable_cnt <= '0;         // Still bouncing or held.
                    end else if (stable_cnt == CNT_LAST) begin
                        key_state  <= uart_baud_pkg::KEY_RELEASED;
                        stable_cnt <= '0;
                    end else begin
                        stable_cnt <= stable_cnt + 1'b1;
                    end
                end
                default: begin
                    key_state  <= uart_baud_pkg::KEY_RELEASED;
                    stable_cnt <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/uart_baud_pkg.sv ====
`default_nettype none

package uart_baud_pkg;

    //////////////////////////////////////////////////
    // Rate index
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        BAUD_9600   = 3'd0,
        BAUD_19200  = 3'd1,
        BAUD_38400  = 3'd2,
        BAUD_57600  = 3'd3,
        BAUD_115200 = 3'd4     // Last step, wraps to BAUD_9600.
    } baud_rate_t;

    //////////////////////////////////////////////////
    // State machines
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        KEY_RELEASED = 2'd0,   // Key up and stable.
        KEY_SETTLING = 2'd1,   // Key down, not yet trusted.
        KEY_PRESSED  = 2'd2    // Press taken, waiting for a stable release.
    } key_state_t;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_t;

endpackage

`default_nettype wire

// ==== source/uart_baud_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_baud_config.svh"

module uart_baud_top #(
    parameter int DEBOUNCE_CYCLES = `UART_DEBOUNCE_CYCLES
) (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        key_in,       // Active low push button.
    input  logic [7:0]  tx_data,
    input  logic        tx_valid,
    output logic        tx_ready,
    output logic        uart_txd,
    output logic [23:0] baud_bcd
);

    logic        key_pulse;
    logic [11:0] bit_divisor;

    //////////////////////////////////////////////////
    // Key press to rate step
    //////////////////////////////////////////////////

    key_filter #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) key_filter_inst (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .key_in    (key_in),
        .key_pulse (key_pulse)
    );

    baud_select baud_select_inst (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .key_pulse   (key_pulse),
        .bit_divisor (bit_divisor),
        .baud_bcd    (baud_bcd)           // Straight to the display pins.
    );

    //////////////////////////////////////////////////
    // Serial line
    //////////////////////////////////////////////////

    uart_tx uart_tx_inst (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .bit_divisor (bit_divisor),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .uart_txd    (uart_txd)
    );

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic [11:0] bit_divisor,
    input  logic [7:0]  tx_data,
    input  logic        tx_valid,
    output logic        tx_ready,
    output logic        uart_txd
);

    uart_baud_pkg::tx_state_t tx_state;

    logic [7:0]  shift_reg;
    logic [11:0] div_latched;     // Bit period for the frame in flight.
    logic [11:0] period_cnt;
    logic [2:0]  bit_cnt;
    logic        accept;
    logic        period_done;

    assign accept      = tx_valid && tx_ready;
    assign period_done = (period_cnt == 12'd0);

    //////////////////////////////////////////////////
    // Frame sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tx_state   <= uart_baud_pkg::TX_IDLE;
            period_cnt <= '0;
            bit_cnt    <= '0;
            tx_ready   <= 1'b1;
            uart_txd   <= 1'b1;                     // Idle line.
        end else begin
            case (tx_state)
                uart_baud_pkg::TX_IDLE: begin
                    if (accept) begin
                        tx_state   <= uart_baud_pkg::TX_START;
                        period_cnt <= bit_divisor - 12'd1;
                        tx_ready   <= 1'b0;
                        uart_txd   <= 1'b0;         // Start bit.
                    end
                end
                uart_baud_pkg::TX_START: begin
                    if (period_done) begin
                        tx_state   <= uart_baud_pkg::TX_DATA;
                        period_cnt <= div_latched - 12'd1;
                        bit_cnt    <= '0;
                        uart_txd   <= shift_reg[0];
                    end else begin
                        period_cnt <= period_cnt - 12'd1;
                    end
                end
                uart_baud_pkg::TX_DATA: begin
                    if (period_done) begin
                        period_cnt <= div_latched - 12'd1;
                        if (bit_cnt == 3'd7) begin
                            tx_state <= uart_baud_pkg::TX_STOP;
                            uart_txd <= 1'b1;       // Stop bit.
                        end else begin
                            bit_cnt  <= bit_cnt + 3'd1;
                            uart_txd <= shift_reg[0];
                        end
                    end else begin
                        period_cnt <= period_cnt - 12'd1;
                    end
                end
                uart_baud_pkg::TX_STOP: begin
                    if (period_done) begin
                        tx_state <= uart_baud_pkg::TX_IDLE;
                        tx_ready <= 1'b1;
                    end else begin
                        period_cnt <= period_cnt - 12'd1;
                    end
                end
                default: begin
                    tx_state <= uart_baud_pkg::TX_IDLE;
                    tx_ready <= 1'b1;
                    uart_txd <= 1'b1;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Payload
    //////////////////////////////////////////////////

    // Shifts right on every bit that leaves for the line, LSB first.
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            shift_reg   <= tx_data;
            div_latched <= bit_divisor;             // Later rate changes wait.
        end else if (period_done && (tx_state == uart_baud_pkg::TX_START ||
                                     tx_state == uart_baud_pkg::TX_DATA)) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/uart_baud_pkg.sv
source/key_filter.sv
source/baud_select.sv
source/uart_tx.sv
source/uart_baud_top.sv
testbench/uart_baud_assertions.sv
testbench/tb_uart_baud.sv

// ==== testbench/tb_uart_baud.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "uart_baud_config.svh"

module tb_uart_baud;

    localparam int DEB = 16;
    localparam int FRAME_CYCLES = 10 * (`UART_DIV_9600 + `UART_DIV_19200 + `UART_DIV_38400
                                  + `UART_DIV_57600 + `UART_DIV_115200)
                                + 10 * (`UART_DIV_9600 + `UART_DIV_19200)
                                + 8 * 10 * `UART_DIV_19200;
    localparam int KEY_CYCLES = 24 * 4 * DEB;       // 16 presses and 8 glitches.
    localparam int TIMEOUT_CYCLES = 2 * (8 + FRAME_CYCLES + KEY_CYCLES);

    logic        sys_clk;
    logic        sys_rst_n;
    logic        key_in;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        tx_ready;
    logic        uart_txd;
    logic [23:0] baud_bcd;

    int errors = 0;
    int test_num = 0;
    int tests_failed = 0;
    int test_start_errors = 0;
    int presses = 0;
    int frames_seen = 0;

    logic [7:0] exp_bytes[$];      // Bytes handed to the DUT, oldest first.
    int         exp_divs[$];

    uart_baud_top #(
        .DEBOUNCE_CYCLES (DEB)
    ) uut (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .key_in    (key_in),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .uart_txd  (uart_txd),
        .baud_bcd  (baud_bcd)
    );

    always #20 sys_clk = ~sys_clk;

    //////////////////////////////////////////////////
    // Reference model and helpers
    //////////////////////////////////////////////////

    // Press count to {bcd, divisor}. Five steps, then back to 9600.
    function automatic logic [35:0] ref_rate(input int count);
        case (count % 5)
            1:       return {24'h019200, 12'(`UART_DIV_19200)};
            2:       return {24'h038400, 12'(`UART_DIV_38400)};
            3:       return {24'h057600, 12'(`UART_DIV_57600)};
            4:       return {24'h115200, 12'(`UART_DIV_115200)};
            default: return {24'h009600, 12'(`UART_DIV_9600)};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", test_num, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // Called on a falling edge. Holds the key low, then high, long enough to count.
    task automatic press_key();
        key_in = 1'b0;
        repeat (2 * DEB) @(negedge sys_clk);
        key_in = 1'b1;
        repeat (2 * DEB) @(negedge sys_clk);
        presses++;
    endtask

    task automatic send_byte(input logic [7:0] data, input int div, input bit keep_valid);
        int low_cycles;
        low_cycles = 0;
        tx_data  = data;
        tx_valid = 1'b1;
        exp_bytes.push_back(data);
        exp_divs.push_back(div);
        while (!tx_ready) @(negedge sys_clk);
        @(negedge sys_clk);                     // Taken on the rising edge between.
        if (!keep_valid) tx_valid = 1'b0;
        while (!tx_ready) begin
            low_cycles++;
            @(negedge sys_clk);
        end
        check_value("tx_ready low cycles", 32'(low_cycles), 32'(10 * div));
    endtask

    //////////////////////////////////////////////////
    // Line monitor
    //////////////////////////////////////////////////

    initial begin : line_monitor
        logic [7:0] want;
        logic [7:0] got;
        int         div;
        wait (sys_rst_n === 1'b1);
        forever begin
            @(negedge uart_txd);
            if (exp_divs.size() == 0) begin
                errors++;
                $display("A start bit appeared on uart_txd with no byte queued.");
            end else begin
                want = exp_bytes.pop_front();
                div  = exp_divs.pop_front();
                repeat (div / 2) @(negedge sys_clk);     // Middle of the start bit.
                check_value("uart_txd start bit", 32'(uart_txd), 32'h0);
                for (int i = 0; i < 8; i++) begin
                    repeat (div) @(negedge sys_clk);
                    got[i] = uart_txd;                  // LSB first.
                end
                repeat (div) @(negedge sys_clk);
                check_value("uart_txd stop bit", 32'(uart_txd), 32'h1);
                check_value("received byte", 32'(got), 32'(want));
                frames_seen++;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * 40);
        $display("The run timed out after %0d clock cycles.", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin : stimulus
        logic [35:0] r;
        int          len;
        int          div;
        int          total;
        void'($urandom(32'h1cf6));
        sys_clk   = 1'b0;
        sys_rst_n = 1'b0;
        key_in    = 1'b1;
        tx_data   = 8'h00;
        tx_valid  = 1'b0;
        repeat (8) @(negedge sys_clk);
        sys_rst_n = 1'b1;
        @(negedge sys_clk);

        r = ref_rate(0);
        check_value("baud_bcd", 32'(baud_bcd), 32'(r[35:12]));
        check_value("tx_ready", 32'(tx_ready), 32'h1);
        check_value("uart_txd", 32'(uart_txd), 32'h1);
        finish_test("reset state");

        for (int g = 0; g < 8; g++) begin
            len = (g == 0) ? DEB - 1 : int'($urandom_range(DEB - 1, 1));
            key_in = 1'b0;
            repeat (len) @(negedge sys_clk);
            key_in = 1'b1;
            repeat (2 * DEB) @(negedge sys_clk);
            r = ref_rate(presses);
            check_value("baud_bcd", 32'(baud_bcd), 32'(r[35:12]));
        end
        finish_test("bounce rejection");

        for (int p = 0; p < 6; p++) begin
            press_key();
            r = ref_rate(presses);
            check_value("baud_bcd", 32'(baud_bcd), 32'(r[35:12]));
        end
        finish_test("rate cycling");

        for (int k = 0; k < 5; k++) begin
            r = ref_rate(presses);
            send_byte(8'($urandom), int'(r[11:0]), 1'b0);
            press_key();
            r = ref_rate(presses);
            check_value("baud_bcd", 32'(baud_bcd), 32'(r[35:12]));
        end
        finish_test("per-rate transmission");

        while (presses % 5 != 0) press_key();
        r   = ref_rate(presses);
        div = int'(r[11:0]);
        fork
            send_byte(8'($urandom), div, 1'b0);
            begin
                repeat (3 * div) @(negedge sys_clk);    // Well inside the frame.
                press_key();
            end
        join
        r = ref_rate(presses);
        check_value("baud_bcd", 32'(baud_bcd), 32'(r[35:12]));
        send_byte(8'($urandom), int'(r[11:0]), 1'b0);
        finish_test("mid-frame rate change");

        r   = ref_rate(presses);
        div = int'(r[11:0]);
        for (int i = 0; i < 8; i++) begin
            send_byte(8'($urandom), div, i != 7);
        end
        if (exp_bytes.size() != 0) begin
            errors++;
            $display("%0d bytes were sent but never seen on uart_txd.", exp_bytes.size());
        end
        finish_test("back-to-back stream");

        total = errors + uut.port_checks.fail_count;
        $display("tests run %0d, failed %0d, frames %0d, check errors %0d, assertion errors %0d",
                 test_num, tests_failed, frames_seen, errors, uut.port_checks.fail_count);
        if (total == 0 && tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/uart_baud_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_baud_assertions (
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic [7:0]  tx_data,
    input  logic        tx_valid,
    input  logic        tx_ready,
    input  logic        uart_txd,
    input  logic [23:0] baud_bcd
);

    int fail_count = 0;     // Read back by the testbench summary.

    // An idle transmitter keeps the line at mark level.
    idle_line_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        tx_ready |-> uart_txd)
    else begin
        $error("uart_txd low while tx_ready is high");
        fail_count++;
    end

    bcd_is_legal: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        baud_bcd inside {24'h009600, 24'h019200, 24'h038400, 24'h057600, 24'h115200})
    else begin
        $error("baud_bcd holds 0x%0h, not one of the five rates", baud_bcd);
        fail_count++;
    end

    // A new byte may appear only right after a handshake.
    data_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (tx_valid && !tx_ready && $past(tx_valid && !tx_ready)) |-> $stable(tx_data))
    else begin
        $error("tx_data changed while the byte was waiting");
        fail_count++;
    end

endmodule

bind uart_baud_top uart_baud_assertions port_checks (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .uart_txd  (uart_txd),
    .baud_bcd  (baud_bcd)
);

`default_nettype wire
